/* cacheController.sv */
`timescale 1ns/100ps

module cacheController (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  cachePkg::wordT   paddr,
    input  cachePkg::wordT   pwdata,
    output cachePkg::wordT   prdata,
    output logic             pready,
    output logic             pslverr,
    output cachePkg::memReqT memReq,
    input  cachePkg::memRspT memRsp,
    input  cachePkg::snoopT  snoop
);
    import cachePkg::*;

    cacheStateT state;
    cacheStateT stateNext;

    // Address fields, held stable by the master until pready.
    tagT   tag;
    indexT idx;
    logic  wordSel;

    // Two ways of 64 sets each.
    lineT            dataArr [2][64];
    tagT             tagArr  [2][64];
    logic [1:0][63:0] validArr;
    // Way to replace next, per set.
    logic [63:0]     lru;

    logic hit0;
    logic hit1;
    logic hit;
    logic fill;
    logic fillWay;
    lineT hitLine;
    wordT hitWord;
    wordT fillWord;
    wordT rDataQ;

    tagT        snoopTag;
    indexT      snoopIdx;
    logic [1:0] snoopHit;

    assign tag     = paddr[18:9];
    assign idx     = paddr[8:3];
    assign wordSel = paddr[2];

    assign hit0 = validArr[0][idx] && (tagArr[0][idx] == tag);
    assign hit1 = validArr[1][idx] && (tagArr[1][idx] == tag);
    assign hit  = hit0 || hit1;

    assign hitLine  = hit1 ? dataArr[1][idx] : dataArr[0][idx];
    assign hitWord  = wordSel ? hitLine[63:32] : hitLine[31:0];
    assign fillWord = wordSel ? memRsp.rData[63:32] : memRsp.rData[31:0];
    assign fillWay  = lru[idx];
    assign fill     = (state == MemWait) && memRsp.done && !pwrite;

    assign snoopTag = snoop.lineAddr[15:6];
    assign snoopIdx = snoop.lineAddr[5:0];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            snoopHit[w] = snoop.valid && validArr[w][snoopIdx] &&
                          (tagArr[w][snoopIdx] == snoopTag);
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            Idle:    if (psel && penable) stateNext = Lookup;
            Lookup:  stateNext = (!pwrite && hit) ? Idle : MemWait;
            MemWait: if (memRsp.done) stateNext = Respond;
            default: stateNext = Idle;
        endcase
    end

    // Hits answer in the lookup cycle, the rest from the captured word.
    assign pready  = ((state == Lookup) && !pwrite && hit) || (state == Respond);
    assign prdata  = (state == Respond) ? rDataQ : hitWord;
    assign pslverr = 1'b0;

    always_comb begin
        memReq.valid    = (state == MemWait);
        memReq.write    = pwrite;
        memReq.lineAddr = {tag, idx};
        memReq.wordSel  = wordSel;
        memReq.wData    = pwdata;
    end

    // Line storage and returned word.
    always_ff @(posedge clk) begin
        if (fill) begin
            dataArr[fillWay][idx] <= memRsp.rData;
            tagArr[fillWay][idx]  <= tag;
        end
        if ((state == MemWait) && memRsp.done) begin
            rDataQ <= fillWord;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= Idle;
            validArr <= '0;
            lru      <= '0;
        end else begin
            state <= stateNext;
            if (state == Lookup && hit) begin
                if (!pwrite) begin
                    lru[idx] <= hit0;
                end else begin
                    // Write-invalidate, the freed way is reused first.
                    validArr[hit1][idx] <= 1'b0;
                    lru[idx]            <= hit1;
                end
            end
            if (fill) begin
                validArr[fillWay][idx] <= 1'b1;
                lru[idx]               <= ~fillWay;
            end
            // Snoop last so it wins over anything above.
            for (int w = 0; w < 2; w++) begin
                if (snoopHit[w]) begin
                    validArr[w][snoopIdx] <= 1'b0;
                end
            end
        end
    end

endmodule

/* cachePkg.sv */
package cachePkg;

    // Data word on APB and in the cache.
    typedef logic [31:0] wordT;

    // Two words per line, low word first.
    typedef logic [63:0] lineT;

    // Tag from address bits 18:9.
    typedef logic [9:0] tagT;

    // Set index from address bits 8:3.
    typedef logic [5:0] indexT;

    // Tag and index together, the SRAM line address.
    typedef logic [15:0] lineAddrT;

    // Memory request from a cache, passed on by the arbiter.
    typedef struct packed {
        logic     valid;
        logic     write;
        lineAddrT lineAddr;
        logic     wordSel;
        wordT     wData;
    } memReqT;

    // Memory response, done pulse with the full line.
    typedef struct packed {
        logic done;
        lineT rData;
    } memRspT;

    // Granted write broadcast to both caches.
    typedef struct packed {
        logic     valid;
        lineAddrT lineAddr;
    } snoopT;

    typedef enum logic [1:0] {Idle, Lookup, MemWait, Respond} cacheStateT;

endpackage

/* cacheSystem.sv */
`timescale 1ns/100ps

module cacheSystem #(
    parameter int SramLatency = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           pselA,
    input  logic           penableA,
    input  logic           pwriteA,
    input  cachePkg::wordT paddrA,
    input  cachePkg::wordT pwdataA,
    output cachePkg::wordT prdataA,
    output logic           preadyA,
    output logic           pslverrA,
    input  logic           pselB,
    input  logic           penableB,
    input  logic           pwriteB,
    input  cachePkg::wordT paddrB,
    input  cachePkg::wordT pwdataB,
    output cachePkg::wordT prdataB,
    output logic           preadyB,
    output logic           pslverrB
);
    import cachePkg::*;

    memReqT reqA, reqB, sramReq;
    memRspT rspA, rspB, sramRsp;
    snoopT  snoop;

    cacheController u_cacheA (
        .clk(clk), .rst(rst), .psel(pselA), .penable(penableA), .pwrite(pwriteA),
        .paddr(paddrA), .pwdata(pwdataA), .prdata(prdataA), .pready(preadyA),
        .pslverr(pslverrA), .memReq(reqA), .memRsp(rspA), .snoop(snoop)
    );

    cacheController u_cacheB (
        .clk(clk), .rst(rst), .psel(pselB), .penable(penableB), .pwrite(pwriteB),
        .paddr(paddrB), .pwdata(pwdataB), .prdata(prdataB), .pready(preadyB),
        .pslverr(pslverrB), .memReq(reqB), .memRsp(rspB), .snoop(snoop)
    );

    memArbiter u_arbiter (
        .clk(clk), .rst(rst), .reqA(reqA), .reqB(reqB), .rspA(rspA), .rspB(rspB),
        .sramReq(sramReq), .sramRsp(sramRsp), .snoop(snoop)
    );

    sramMemory #(.SramLatency(SramLatency)) u_sram (
        .clk(clk), .rst(rst), .req(sramReq), .rsp(sramRsp)
    );

endmodule

/* cacheSystem_sva.sv */
`timescale 1ns/100ps

module cacheSystem_sva (
    input logic             clk,
    input logic             rst,
    input logic             pselA,
    input logic             penableA,
    input logic             pwriteA,
    input cachePkg::wordT   paddrA,
    input logic             preadyA,
    input logic             pselB,
    input logic             penableB,
    input logic             pwriteB,
    input cachePkg::wordT   paddrB,
    input logic             preadyB,
    input cachePkg::memReqT reqA,
    input cachePkg::memReqT reqB,
    input cachePkg::memRspT rspA,
    input cachePkg::memRspT rspB,
    input cachePkg::memReqT sramReq,
    input cachePkg::memRspT sramRsp,
    input cachePkg::snoopT  snoop
);
    import cachePkg::*;

    // Set by a forwarded request, cleared by its done.
    logic pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (sramReq.valid) begin
            pending <= 1'b1;
        end else if (sramRsp.done) begin
            pending <= 1'b0;
        end
    end

    apbStableA: assert property (@(posedge clk) disable iff (rst)
        (pselA && penableA && !preadyA) |=> pselA && $stable(paddrA) && $stable(pwriteA))
        else $error("Port A address or control changed before pready");

    apbStableB: assert property (@(posedge clk) disable iff (rst)
        (pselB && penableB && !preadyB) |=> pselB && $stable(paddrB) && $stable(pwriteB))
        else $error("Port B address or control changed before pready");

    reqStableA: assert property (@(posedge clk) disable iff (rst)
        (reqA.valid && !rspA.done) |=> reqA.valid && $stable(reqA))
        else $error("Port A memory request changed before done");

    reqStableB: assert property (@(posedge clk) disable iff (rst)
        (reqB.valid && !rspB.done) |=> reqB.valid && $stable(reqB))
        else $error("Port B memory request changed before done");

    doneGranted: assert property (@(posedge clk) disable iff (rst)
        sramRsp.done |-> pending)
        else $error("SRAM done without a pending grant");

    // The snooped line must belong to a write that a cache is holding.
    snoopOnWrite: assert property (@(posedge clk) disable iff (rst)
        snoop.valid |-> (reqA.valid && reqA.write && reqA.lineAddr == snoop.lineAddr) ||
                        (reqB.valid && reqB.write && reqB.lineAddr == snoop.lineAddr))
        else $error("Snoop without a granted write");

endmodule

bind cacheSystem cacheSystem_sva u_sva (
    .clk(clk), .rst(rst),
    .pselA(pselA), .penableA(penableA), .pwriteA(pwriteA), .paddrA(paddrA),
    .preadyA(preadyA),
    .pselB(pselB), .penableB(penableB), .pwriteB(pwriteB), .paddrB(paddrB),
    .preadyB(preadyB),
    .reqA(reqA), .reqB(reqB), .rspA(rspA), .rspB(rspB),
    .sramReq(sramReq), .sramRsp(sramRsp), .snoop(snoop)
);

/* memArbiter.sv */
`timescale 1ns/100ps

module memArbiter (
    input  logic             clk,
    input  logic             rst,
    input  cachePkg::memReqT reqA,
    input  cachePkg::memReqT reqB,
    output cachePkg::memRspT rspA,
    output cachePkg::memRspT rspB,
    output cachePkg::memReqT sramReq,
    input  cachePkg::memRspT sramRsp,
    output cachePkg::snoopT  snoop
);
    import cachePkg::*;

    logic   busy;
    logic   fwd;
    logic   grantB;
    logic   lastB;
    logic   pickB;
    memReqT sel;

    // The port not served last wins a tie.
    assign pickB = (reqA.valid && reqB.valid) ? !lastB : reqB.valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            fwd    <= 1'b0;
            grantB <= 1'b0;
            lastB  <= 1'b0;
        end else begin
            fwd <= 1'b0;
            if (!busy) begin
                if (reqA.valid || reqB.valid) begin
                    busy   <= 1'b1;
                    fwd    <= 1'b1;
                    grantB <= pickB;
                end
            end else if (sramRsp.done) begin
                busy  <= 1'b0;
                lastB <= grantB;
            end
        end
    end

    assign sel = grantB ? reqB : reqA;

    // One-cycle forward in the grant cycle.
    always_comb begin
        sramReq       = sel;
        sramReq.valid = fwd;
        snoop.valid    = fwd && sel.write;
        snoop.lineAddr = sel.lineAddr;
    end

    // Done goes to the granted port only.
    assign rspA.done  = sramRsp.done && busy && !grantB;
    assign rspA.rData = sramRsp.rData;
    assign rspB.done  = sramRsp.done && busy && grantB;
    assign rspB.rData = sramRsp.rData;

endmodule

/* sramMemory.sv */
`timescale 1ns/100ps

module sramMemory #(
    parameter int SramLatency = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  cachePkg::memReqT req,
    output cachePkg::memRspT rsp
);
    import cachePkg::*;

    localparam int CntW = $clog2(SramLatency + 1);

    lineT mem [65536];

    logic            busy;
    logic            doneQ;
    logic [CntW-1:0] count;
    memReqT          reqQ;
    lineT            rDataQ;
    logic            finish;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = '0;
        end
    end

    // Last counted cycle, done follows on the next edge.
    assign finish = busy && (count == CntW'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            doneQ <= 1'b0;
            count <= '0;
        end else begin
            doneQ <= finish;
            if (req.valid) begin
                busy  <= 1'b1;
                count <= CntW'(SramLatency - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (finish) busy <= 1'b0;
            end
        end
    end

    // Array access on the edge that raises done.
    always_ff @(posedge clk) begin
        if (req.valid) reqQ <= req;
        if (finish) begin
            rDataQ <= mem[reqQ.lineAddr];
            if (reqQ.write && reqQ.wordSel) mem[reqQ.lineAddr][63:32] <= reqQ.wData;
            if (reqQ.write && !reqQ.wordSel) mem[reqQ.lineAddr][31:0] <= reqQ.wData;
        end
    end

    assign rsp.done  = doneQ;
    assign rsp.rData = rDataQ;

endmodule

/* tb_cacheSystem.sv */
`timescale 1ns/100ps

module tb_cacheSystem;
    import cachePkg::*;

    localparam int NumOps = 400;
    // 900 transactions at 30 cycles each.
    localparam int CycleLimit = 900 * 30;

    logic clk;
    logic rst;
    logic pselA, penableA, pwriteA, preadyA, pslverrA;
    logic pselB, penableB, pwriteB, preadyB, pslverrB;
    wordT paddrA, pwdataA, prdataA;
    wordT paddrB, pwdataB, prdataB;

    // Reference memory, indexed by word address.
    wordT model [int];
    int   seed;
    int   cycleCount;
    logic opA [NumOps];
    logic opB [NumOps];
    wordT adrA [NumOps];
    wordT adrB [NumOps];
    wordT datA [NumOps];
    wordT datB [NumOps];

    cacheSystem #(.SramLatency(4)) u_dut (
        .clk(clk), .rst(rst),
        .pselA(pselA), .penableA(penableA), .pwriteA(pwriteA), .paddrA(paddrA),
        .pwdataA(pwdataA), .prdataA(prdataA), .preadyA(preadyA), .pslverrA(pslverrA),
        .pselB(pselB), .penableB(penableB), .pwriteB(pwriteB), .paddrB(paddrB),
        .pwdataB(pwdataB), .prdataB(prdataB), .preadyB(preadyB), .pslverrB(pslverrB)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run hung, no finish after %0d cycles.", CycleLimit);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

    function automatic wordT modelWord(input wordT addr);
        if (model.exists(addr >> 2)) return model[addr >> 2];
        return '0;
    endfunction

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error: %s expected %0d cycles actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Latency mismatch");
        end
    endtask

    // One APB transfer on port A; cycles counts access-phase cycles.
    task automatic apbA(input logic wr, input wordT addr, input wordT wdata,
                        output wordT rdata, output logic err, output int cycles);
        @(posedge clk);
        #1;
        pselA = 1'b1;
        penableA = 1'b0;
        pwriteA = wr;
        paddrA = addr;
        pwdataA = wdata;
        @(posedge clk);
        #1;
        penableA = 1'b1;
        cycles = 1;
        @(negedge clk);
        while (!preadyA) begin
            @(negedge clk);
            cycles++;
        end
        rdata = prdataA;
        err = pslverrA;
        @(posedge clk);
        #1;
        pselA = 1'b0;
        penableA = 1'b0;
    endtask

    task automatic apbB(input logic wr, input wordT addr, input wordT wdata,
                        output wordT rdata, output logic err, output int cycles);
        @(posedge clk);
        #1;
        pselB = 1'b1;
        penableB = 1'b0;
        pwriteB = wr;
        paddrB = addr;
        pwdataB = wdata;
        @(posedge clk);
        #1;
        penableB = 1'b1;
        cycles = 1;
        @(negedge clk);
        while (!preadyB) begin
            @(negedge clk);
            cycles++;
        end
        rdata = prdataB;
        err = pslverrB;
        @(posedge clk);
        #1;
        pselB = 1'b0;
        penableB = 1'b0;
    endtask

    task automatic access(input logic portB, input logic wr, input wordT addr,
                          input wordT wdata, input string name, output int cycles);
        wordT rdata;
        logic err;
        if (portB) apbB(wr, addr, wdata, rdata, err, cycles);
        else apbA(wr, addr, wdata, rdata, err, cycles);
        checkFlag(name, 1'b0, err);
        if (wr) model[addr >> 2] = wdata;
        else checkWord(name, modelWord(addr), rdata);
    endtask

    initial begin
        int cyc;
        pselA = 0;
        penableA = 0;
        pwriteA = 0;
        paddrA = '0;
        pwdataA = '0;
        pselB = 0;
        penableB = 0;
        pwriteB = 0;
        paddrB = '0;
        pwdataB = '0;
        rst = 1'b1;
        seed = 76464;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        if (preadyA !== 1'b0 || preadyB !== 1'b0) begin
            $display("pready was not low right after reset.");
            $display("*** TEST FAILED ***");
            $fatal(1, "Reset state");
        end
        access(0, 0, 32'h0000_0104, '0, "resetRead", cyc);

        // Miss, then a hit with fixed latency.
        access(0, 1, 32'h0000_5000, 32'hA5A5_1234, "missHitWrite", cyc);
        access(0, 0, 32'h0000_5000, '0, "missRead", cyc);
        access(0, 0, 32'h0000_5000, '0, "hitRead", cyc);
        checkCycles("hitLatency", 2, cyc);

        // Stimulus drawn up front so both ports see a fixed sequence.
        for (int i = 0; i < NumOps; i++) begin
            opA[i] = 1'($random(seed));
            adrA[i] = $random(seed) & 32'h0000_0E74;
            datA[i] = $random(seed);
            opB[i] = 1'($random(seed));
            adrB[i] = ($random(seed) & 32'h0000_0E74) | 32'h8;
            datB[i] = $random(seed);
        end
        fork
            begin
                int c;
                for (int i = 0; i < NumOps; i++) begin
                    access(0, opA[i], adrA[i], datA[i], "randomA", c);
                end
            end
            begin
                int c;
                for (int i = 0; i < NumOps; i++) begin
                    access(1, opB[i], adrB[i], datB[i], "randomB", c);
                end
            end
        join

        // Three tags in set 5.
        access(0, 1, 32'h0000_1028, 32'h1111_0001, "lruWriteX", cyc);
        access(0, 1, 32'h0000_2028, 32'h2222_0002, "lruWriteY", cyc);
        access(0, 1, 32'h0000_3028, 32'h3333_0003, "lruWriteZ", cyc);
        access(0, 0, 32'h0000_1028, '0, "lruReadX", cyc);
        access(0, 0, 32'h0000_2028, '0, "lruReadY", cyc);
        access(0, 0, 32'h0000_1028, '0, "lruReadX2", cyc);
        // X and Y both resident after two fills.
        checkCycles("lruHitX2", 2, cyc);
        access(0, 0, 32'h0000_3028, '0, "lruReadZ", cyc);
        access(0, 0, 32'h0000_1028, '0, "lruReadX3", cyc);
        // Z must have replaced Y, so X still hits.
        checkCycles("lruHitX3", 2, cyc);

        // Cross-port write-invalidate through the snoop.
        access(0, 0, 32'h0000_4100, '0, "snoopFillA", cyc);
        access(1, 1, 32'h0000_4100, 32'hBEEF_0001, "snoopWriteB", cyc);
        access(0, 0, 32'h0000_4100, '0, "snoopReadA", cyc);
        access(1, 0, 32'h0000_4100, '0, "snoopFillB", cyc);
        access(0, 1, 32'h0000_4100, 32'hBEEF_0002, "snoopWriteA", cyc);
        access(1, 0, 32'h0000_4100, '0, "snoopReadB", cyc);
        access(0, 0, 32'h0000_4100, '0, "ownFillA", cyc);
        access(0, 1, 32'h0000_4100, 32'hBEEF_0003, "ownWriteA", cyc);
        access(0, 0, 32'h0000_4100, '0, "ownReadA", cyc);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
cachePkg.sv
cacheController.sv
memArbiter.sv
sramMemory.sv
cacheSystem.sv
cacheSystem_sva.sv
tb_cacheSystem.sv
